// File: design/board_pkg.sv
// Shared widths, memory map and address views; the map holds only the regions modelled here
package board_pkg;

	// ====================================================================
	// Bus widths
	// ====================================================================
	localparam int addr_w     = 16;              // MC6809E address bus
	localparam int data_w     = 8;               // Data bus
	localparam int rom_addr_w = 17;              // 15 images of 4 KB, linear
	localparam int rom_img_w  = rom_addr_w - 12; // Image index above the 4 KB offset
	localparam int ram_addr_w = 11;              // 2 KB work RAM
	localparam int bank_w     = 4;               // Bank-select register

	// ROM layout, banked images sit right after the main ones
	localparam int bank_count      = 9;
	localparam int main_rom_images = 6;

	// ====================================================================
	// Memory map
	// ====================================================================
	localparam logic [3:0] region_main_first = 4'hA; // 0xA000-0xFFFF main program
	localparam logic [3:0] region_bank       = 4'h9; // 0x9000-0x9FFF banked window
	localparam logic [3:0] region_ram        = 4'h8; // Upper half is work RAM

	// 16-byte read pages in the I/O area
	localparam logic [11:0] io_page_dsw2 = 12'h816;
	localparam logic [11:0] io_page_in0  = 12'h818; // Coins and start
	localparam logic [11:0] io_page_in1  = 12'h81A; // Player 1
	localparam logic [11:0] io_page_in2  = 12'h81C; // Player 2
	localparam logic [11:0] io_page_dsw1 = 12'h81E;

	// 256-byte write pages
	localparam logic [7:0] page_latch    = 8'h82;
	localparam logic [7:0] page_banksel  = 8'h83;
	localparam logic [7:0] page_soundcmd = 8'h87;

	// Main latch bits, picked by A2..A0
	localparam logic [2:0] latch_nmi_mask  = 3'd0;
	localparam logic [2:0] latch_flip      = 3'd1;
	localparam logic [2:0] latch_sound_irq = 3'd2;

	localparam logic [7:0] open_bus = 8'hFF; // Unmapped reads

	// One CPU address, seen as memory or as I/O
	typedef union packed {
		struct packed {
			logic [3:0]  region; // 4 KB region
			logic [11:0] offset;
		} mem;
		struct packed {
			logic [11:0] page;   // 16-byte page
			logic [3:0]  reg_sel;
		} io;
	} cpu_addr_u;

endpackage

// File: design/clock_gen.sv
// Assumes clk_49m at 49.152 MHz; pause_i freezes only E and Q, the pixel enables keep running
`timescale 1ns/1ps

module clock_gen (
	input  logic clk_49m,
	input  logic reset,    // Synchronous, active low
	input  logic pause_i,
	output logic cen_6m_o, // 6.144 MHz enable
	output logic cen_3m_o, // 3.072 MHz enable
	output logic cpu_e_o,  // 1.536 MHz E phase
	output logic cpu_q_o   // Q, a quarter period behind E
);

	logic [3:0] div;     // Free-running enable divider
	logic [4:0] cpu_div; // One E cycle is 32 clocks

	// ====================================================================
	// Pixel and bus enables
	// ====================================================================
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			div <= 4'd0;
		end else begin
			div <= div + 4'd1;
		end
	end

	assign cen_6m_o = (div[2:0] == 3'd0); // Every 8 clocks
	assign cen_3m_o = (div == 4'd0);      // Every 16 clocks

	// ====================================================================
	// MC6809E E and Q phases
	// ====================================================================
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			cpu_div <= 5'd0;
			cpu_e_o <= 1'b0;
			cpu_q_o <= 1'b0;
		end else if (!pause_i) begin // Held while paused
			cpu_div <= cpu_div + 5'd1;
			case (cpu_div)
				5'd0:  cpu_e_o <= 1'b1; // E rises
				5'd8:  cpu_q_o <= 1'b1; // Q follows 8 clocks on
				5'd16: cpu_e_o <= 1'b0;
				5'd24: cpu_q_o <= 1'b0;
				default: ;
			endcase
		end
	end

	// The two phases stay in quadrature, so no edge of E meets an edge of Q
	a_eq_apart: assert property (@(posedge clk_49m) disable iff (!reset)
		!($changed(cpu_e_o) && $changed(cpu_q_o)));

endmodule

// File: design/addr_decoder.sv
// Decodes a stable CPU address; write strobes last one clock per cen_3m pulse, no bus handshake
`timescale 1ns/1ps

module addr_decoder (
	input  board_pkg::cpu_addr_u              cpu_addr_i,
	input  logic                              cpu_rnw_i,  // High for read
	input  logic                              cen_3m_i,
	input  logic [board_pkg::bank_w-1:0]      rom_bank_i,
	output logic                              sel_rom_o,
	output logic                              sel_ram_o,
	output logic                              sel_dsw1_o,
	output logic                              sel_dsw2_o,
	output logic                              sel_in0_o,
	output logic                              sel_in1_o,
	output logic                              sel_in2_o,
	output logic                              wr_ram_o,
	output logic                              wr_latch_o,
	output logic                              wr_bank_o,
	output logic                              cs_sounddata_o,
	output logic [board_pkg::rom_addr_w-1:0]  rom_addr_o
);

	import board_pkg::*;

	logic                 main_rom;  // 0xA000-0xFFFF
	logic                 bank_win;  // 0x9000-0x9FFF
	logic                 bank_ok;   // Bank has an image behind it
	logic                 cpu_write;
	logic [7:0]           wr_page;   // A15..A8
	logic [rom_img_w-1:0] rom_img;   // Linear image index

	// ====================================================================
	// Memory view
	// ====================================================================
	assign main_rom = (cpu_addr_i.mem.region >= region_main_first);
	assign bank_win = (cpu_addr_i.mem.region == region_bank);
	assign bank_ok  = (rom_bank_i < bank_count);

	assign sel_rom_o = main_rom | (bank_win & bank_ok); // Banks 9..15 read open bus
	assign sel_ram_o = (cpu_addr_i.mem.region == region_ram) & cpu_addr_i.mem.offset[11];

	// Banked images are stored after the six main images
	always_comb begin
		if (bank_win) begin
			rom_img = rom_img_w'(main_rom_images) + rom_img_w'(rom_bank_i);
		end else begin
			rom_img = rom_img_w'(cpu_addr_i.mem.region - region_main_first);
		end
	end

	assign rom_addr_o = {rom_img, cpu_addr_i.mem.offset};

	// ====================================================================
	// I/O view
	// ====================================================================
	assign sel_dsw1_o = (cpu_addr_i.io.page == io_page_dsw1);
	assign sel_dsw2_o = (cpu_addr_i.io.page == io_page_dsw2);
	assign sel_in0_o  = (cpu_addr_i.io.page == io_page_in0);
	assign sel_in1_o  = (cpu_addr_i.io.page == io_page_in1);
	assign sel_in2_o  = (cpu_addr_i.io.page == io_page_in2);

	assign wr_page   = cpu_addr_i.io.page[11:4];
	assign cpu_write = ~cpu_rnw_i;

	// Writes land once per cen_3m pulse
	assign wr_ram_o   = sel_ram_o & cpu_write & cen_3m_i;
	assign wr_latch_o = (wr_page == page_latch) & cpu_write & cen_3m_i;
	assign wr_bank_o  = (wr_page == page_banksel) & cpu_write & cen_3m_i;

	// Level for the sound board while the write sits on the bus
	assign cs_sounddata_o = (wr_page == page_soundcmd) & cpu_write;

endmodule

// File: design/board_regs.sv
// Bank register, main latch and VBlank NMI; vblank_irq_i must stay high for 8 clocks or more
`timescale 1ns/1ps

module board_regs (
	input  logic                             clk_49m,
	input  logic                             reset,        // Synchronous, active low
	input  logic                             cen_6m_i,
	input  board_pkg::cpu_addr_u             cpu_addr_i,
	input  logic [board_pkg::data_w-1:0]     cpu_dout_i,
	input  logic                             wr_latch_i,   // Already qualified by cen_3m
	input  logic                             wr_bank_i,
	input  logic                             vblank_irq_i,
	output logic [board_pkg::bank_w-1:0]     rom_bank_o,
	output logic                             flip_o,
	output logic                             irq_trigger_o,
	output logic                             nmi_n_o
);

	import board_pkg::*;

	logic       nmi_mask;
	logic       sound_irq;
	logic [2:0] latch_sel; // A2..A0

	assign latch_sel = cpu_addr_i.io.reg_sel[2:0];

	// ====================================================================
	// ROM bank select, 0x83xx
	// ====================================================================
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			rom_bank_o <= '0;
		end else if (wr_bank_i) begin
			rom_bank_o <= cpu_dout_i[bank_w-1:0]; // Only D3..D0 are wired
		end
	end

	// ====================================================================
	// Main latch, 0x82xx
	// ====================================================================
	// Addressable latch, D0 goes to the bit chosen by A2..A0
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			nmi_mask  <= 1'b0;
			flip_o    <= 1'b0;
			sound_irq <= 1'b0;
		end else if (wr_latch_i) begin
			case (latch_sel)
				latch_nmi_mask:  nmi_mask  <= cpu_dout_i[0];
				latch_flip:      flip_o    <= cpu_dout_i[0];
				latch_sound_irq: sound_irq <= cpu_dout_i[0];
				default: ; // Pixel enable and the rest live elsewhere
			endcase
		end
	end

	assign irq_trigger_o = sound_irq; // Straight to the sound board

	// ====================================================================
	// VBlank NMI
	// ====================================================================
	// Re-evaluated every pixel enable, so one sampled pulse gives 8 clocks low
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			nmi_n_o <= 1'b1;
		end else if (cen_6m_i) begin
			nmi_n_o <= ~(nmi_mask & vblank_irq_i);
		end
	end

	// NMI can only start from a set mask, even if the CPU clears it while low
	a_nmi_masked: assert property (@(posedge clk_49m) disable iff (!reset)
		$fell(nmi_n_o) |-> $past(nmi_mask));

endmodule

// File: design/work_ram.sv
// 2 KB single-port RAM, read data one clock after the address; old data returned on a write
`timescale 1ns/1ps

module work_ram (
	input  logic                               clk_49m,
	input  logic                               we_i,
	input  logic [board_pkg::ram_addr_w-1:0]   addr_i,
	input  logic [board_pkg::data_w-1:0]       data_i,
	output logic [board_pkg::data_w-1:0]       q_o
);

	import board_pkg::*;

	logic [data_w-1:0] mem [2**ram_addr_w]; // 2048 bytes

	// Registered read, same port as the write
	always_ff @(posedge clk_49m) begin
		if (we_i) begin
			mem[addr_i] <= data_i;
		end
		q_o <= mem[addr_i];
	end

	// The decoder only strobes a write on a settled CPU address
	a_addr_known: assert property (@(posedge clk_49m)
		we_i |-> !$isunknown(addr_i));

endmodule

// File: design/cpu_read_mux.sv
// CPU read data one clock after the address; switches and controls are active low on the pins
`timescale 1ns/1ps

module cpu_read_mux (
	input  logic                               clk_49m,
	input  logic                               reset,       // Synchronous, active low
	input  logic                               sel_rom_i,
	input  logic                               sel_ram_i,
	input  logic                               sel_dsw1_i,
	input  logic                               sel_dsw2_i,
	input  logic                               sel_in0_i,
	input  logic                               sel_in1_i,
	input  logic                               sel_in2_i,
	input  logic [board_pkg::data_w-1:0]       ram_q_i,     // Already one clock late
	input  logic [board_pkg::data_w-1:0]       rom_data_i,  // Same
	input  logic [2*board_pkg::data_w-1:0]     dip_sw_i,
	input  logic [board_pkg::data_w-1:0]       in0_i,
	input  logic [board_pkg::data_w-1:0]       in1_i,
	input  logic [board_pkg::data_w-1:0]       in2_i,
	output logic [board_pkg::data_w-1:0]       cpu_din_o
);

	import board_pkg::*;

	logic sel_rom_q, sel_ram_q, sel_dsw1_q, sel_dsw2_q;
	logic sel_in0_q, sel_in1_q, sel_in2_q;
	logic [data_w-1:0] dsw1_q, dsw2_q, in0_q, in1_q, in2_q;

	// ====================================================================
	// Match the memory latency
	// ====================================================================
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			sel_rom_q  <= 1'b0;
			sel_ram_q  <= 1'b0;
			sel_dsw1_q <= 1'b0;
			sel_dsw2_q <= 1'b0;
			sel_in0_q  <= 1'b0;
			sel_in1_q  <= 1'b0;
			sel_in2_q  <= 1'b0;
		end else begin
			sel_rom_q  <= sel_rom_i;
			sel_ram_q  <= sel_ram_i;
			sel_dsw1_q <= sel_dsw1_i;
			sel_dsw2_q <= sel_dsw2_i;
			sel_in0_q  <= sel_in0_i;
			sel_in1_q  <= sel_in1_i;
			sel_in2_q  <= sel_in2_i;
		end
	end

	// Inverted here, the CPU sees active high
	always_ff @(posedge clk_49m) begin
		dsw1_q <= ~dip_sw_i[data_w-1:0];        // DSW1 is the low byte
		dsw2_q <= ~dip_sw_i[2*data_w-1:data_w];
		in0_q  <= ~in0_i;
		in1_q  <= ~in1_i;
		in2_q  <= ~in2_i;
	end

	// Priority pick, unmapped space reads open bus
	always_comb begin
		if (sel_rom_q)       cpu_din_o = rom_data_i;
		else if (sel_ram_q)  cpu_din_o = ram_q_i;
		else if (sel_dsw1_q) cpu_din_o = dsw1_q;
		else if (sel_dsw2_q) cpu_din_o = dsw2_q;
		else if (sel_in0_q)  cpu_din_o = in0_q;
		else if (sel_in1_q)  cpu_din_o = in1_q;
		else if (sel_in2_q)  cpu_din_o = in2_q;
		else                 cpu_din_o = open_bus;
	end

endmodule

// File: design/tutankham_board.sv
// Tutankham CPU board decode and control; external 6809 core and ROM, video side reads as 0xFF
`timescale 1ns/1ps

module tutankham_board (
	input  logic                               clk_49m,        // 49.152 MHz master
	input  logic                               reset,          // Synchronous, active low
	input  logic                               pause_i,
	// CPU bus
	input  logic [board_pkg::addr_w-1:0]       cpu_addr_i,
	input  logic [board_pkg::data_w-1:0]       cpu_dout_i,
	input  logic                               cpu_rnw_i,
	output logic [board_pkg::data_w-1:0]       cpu_din_o,
	output logic                               cpu_e_o,
	output logic                               cpu_q_o,
	output logic                               nmi_n_o,
	// External program and bank ROM
	output logic [board_pkg::rom_addr_w-1:0]   rom_addr_o,
	input  logic [board_pkg::data_w-1:0]       rom_data_i,
	// Board pins
	input  logic [2*board_pkg::data_w-1:0]     dip_sw_i,       // Active low
	input  logic [board_pkg::data_w-1:0]       in0_i,
	input  logic [board_pkg::data_w-1:0]       in1_i,
	input  logic [board_pkg::data_w-1:0]       in2_i,
	input  logic                               vblank_irq_i,
	output logic                               cs_sounddata_o,
	output logic                               irq_trigger_o,
	output logic                               flip_o
);

	import board_pkg::*;

	logic              cen_6m, cen_3m;
	logic              sel_rom, sel_ram, sel_dsw1, sel_dsw2;
	logic              sel_in0, sel_in1, sel_in2;
	logic              wr_ram, wr_latch, wr_bank;
	logic [bank_w-1:0] rom_bank;
	logic [data_w-1:0] ram_q;

	// ====================================================================
	// Clocking
	// ====================================================================
	clock_gen i_clock_gen (
		.clk_49m  (clk_49m),
		.reset    (reset),
		.pause_i  (pause_i),
		.cen_6m_o (cen_6m),
		.cen_3m_o (cen_3m),
		.cpu_e_o  (cpu_e_o),
		.cpu_q_o  (cpu_q_o)
	);

	// ====================================================================
	// Decoded bus
	// ====================================================================
	addr_decoder i_addr_decoder (
		.cpu_addr_i     (cpu_addr_i),  // Same 16 bits, union view
		.cpu_rnw_i      (cpu_rnw_i),
		.cen_3m_i       (cen_3m),
		.rom_bank_i     (rom_bank),
		.sel_rom_o      (sel_rom),
		.sel_ram_o      (sel_ram),
		.sel_dsw1_o     (sel_dsw1),
		.sel_dsw2_o     (sel_dsw2),
		.sel_in0_o      (sel_in0),
		.sel_in1_o      (sel_in1),
		.sel_in2_o      (sel_in2),
		.wr_ram_o       (wr_ram),
		.wr_latch_o     (wr_latch),
		.wr_bank_o      (wr_bank),
		.cs_sounddata_o (cs_sounddata_o),
		.rom_addr_o     (rom_addr_o)
	);

	board_regs i_board_regs (
		.clk_49m       (clk_49m),
		.reset         (reset),
		.cen_6m_i      (cen_6m),
		.cpu_addr_i    (cpu_addr_i),
		.cpu_dout_i    (cpu_dout_i),
		.wr_latch_i    (wr_latch),
		.wr_bank_i     (wr_bank),
		.vblank_irq_i  (vblank_irq_i),
		.rom_bank_o    (rom_bank),
		.flip_o        (flip_o),
		.irq_trigger_o (irq_trigger_o),
		.nmi_n_o       (nmi_n_o)
	);

	work_ram i_work_ram (
		.clk_49m (clk_49m),
		.we_i    (wr_ram),
		.addr_i  (cpu_addr_i[ram_addr_w-1:0]), // 0x8800-0x8FFF
		.data_i  (cpu_dout_i),
		.q_o     (ram_q)
	);

	// ====================================================================
	// Read path
	// ====================================================================
	cpu_read_mux i_cpu_read_mux (
		.clk_49m    (clk_49m),
		.reset      (reset),
		.sel_rom_i  (sel_rom),
		.sel_ram_i  (sel_ram),
		.sel_dsw1_i (sel_dsw1),
		.sel_dsw2_i (sel_dsw2),
		.sel_in0_i  (sel_in0),
		.sel_in1_i  (sel_in1),
		.sel_in2_i  (sel_in2),
		.ram_q_i    (ram_q),
		.rom_data_i (rom_data_i),
		.dip_sw_i   (dip_sw_i),
		.in0_i      (in0_i),
		.in1_i      (in1_i),
		.in2_i      (in2_i),
		.cpu_din_o  (cpu_din_o)
	);

endmodule

// File: dv/tb_tutankham_board.sv
// Bus cycles last one E period with no 6809 core; ROM is a model answering one clock after rom_addr_o
`timescale 1ns/1ps

module tb_tutankham_board;

	import board_pkg::*;

	logic                    clk_49m;
	logic                    reset;
	logic                    pause_i;
	logic [addr_w-1:0]       cpu_addr_i;
	logic [data_w-1:0]       cpu_dout_i;
	logic                    cpu_rnw_i;
	logic [data_w-1:0]       cpu_din_o;
	logic                    cpu_e_o, cpu_q_o, nmi_n_o;
	logic [rom_addr_w-1:0]   rom_addr_o;
	logic [data_w-1:0]       rom_data_i = '0;
	logic [2*data_w-1:0]     dip_sw_i;
	logic [data_w-1:0]       in0_i, in1_i, in2_i;
	logic                    vblank_irq_i;
	logic                    cs_sounddata_o, irq_trigger_o, flip_o;

	int errors;
	int checks;

	// Stimulus table, one row per E cycle
	bit                tbl_wr[$];
	logic [addr_w-1:0] tbl_addr[$];
	logic [data_w-1:0] tbl_wdata[$];
	logic [data_w-1:0] tbl_exp[$];   // Read rows only

	logic [data_w-1:0] ram_val [3];  // RAM data as drawn

	tutankham_board i_tutankham_board (
		.clk_49m (clk_49m), .reset (reset), .pause_i (pause_i),
		.cpu_addr_i (cpu_addr_i), .cpu_dout_i (cpu_dout_i), .cpu_rnw_i (cpu_rnw_i),
		.cpu_din_o (cpu_din_o), .cpu_e_o (cpu_e_o), .cpu_q_o (cpu_q_o), .nmi_n_o (nmi_n_o),
		.rom_addr_o (rom_addr_o), .rom_data_i (rom_data_i),
		.dip_sw_i (dip_sw_i), .in0_i (in0_i), .in1_i (in1_i), .in2_i (in2_i),
		.vblank_irq_i (vblank_irq_i), .cs_sounddata_o (cs_sounddata_o),
		.irq_trigger_o (irq_trigger_o), .flip_o (flip_o)
	);

	// ====================================================================
	// Clock and external ROM
	// ====================================================================
	initial begin
		clk_49m = 1'b0;
		forever #5 clk_49m = ~clk_49m; // 10 ns period
	end

	// Image index above, 4 KB offset below
	function automatic logic [7:0] rom_byte(input logic [16:0] addr);
		return addr[7:0] ^ {addr[16:12], 3'b000};
	endfunction

	always @(posedge clk_49m) rom_data_i <= rom_byte(rom_addr_o); // One clock late

	// ====================================================================
	// Helpers
	// ====================================================================
	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual,
				expected);
		end
	endtask

	task automatic add_table_row(input bit wr, input logic [15:0] addr, input logic [7:0] wdata,
		input logic [7:0] exp);
		tbl_wr.push_back(wr);
		tbl_addr.push_back(addr);
		tbl_wdata.push_back(wdata);
		tbl_exp.push_back(exp);
	endtask

	// Called 1 ns after a rising edge, returns at the same point
	task automatic wait_e_level(input logic level);
		int n;
		n = 0;
		while (cpu_e_o !== level && n < 64) begin
			@(posedge clk_49m);
			#1;
			n++;
		end
		if (cpu_e_o !== level) begin
			errors++;
			$display("Timeout: cpu_e_o did not reach %b within 64 clocks at %0t", level, $time);
		end
	endtask

	// Address goes out just after E falls, data is taken at the next fall
	task automatic run_bus_cycle(input bit wr, input logic [15:0] addr, input logic [7:0] wdata,
		output logic [7:0] din, output bit cs);
		cpu_addr_i = addr;
		cpu_rnw_i  = ~wr;
		cpu_dout_i = wr ? wdata : 8'h00;
		wait_e_level(1'b1);
		wait_e_level(1'b0);
		din = cpu_din_o;
		cs  = cs_sounddata_o; // Address still on the bus here
	endtask

	// 8-clock vblank pulse, then count how long nmi_n_o stays low
	task automatic pulse_vblank(output int low_clocks, output bit back_high);
		int  n;
		bit  seen_low;
		low_clocks   = 0;
		back_high    = 1'b0;
		seen_low     = 1'b0;
		vblank_irq_i = 1'b1;
		for (n = 0; n < 48; n++) begin // 48-clock limit
			@(posedge clk_49m);
			#1;
			if (n == 7) vblank_irq_i = 1'b0; // High over 8 rising edges
			if (!nmi_n_o) begin
				seen_low = 1'b1;
				low_clocks++;
			end else if (seen_low) begin
				back_high = 1'b1;
				break;
			end
		end
		vblank_irq_i = 1'b0;
	endtask

	// Clocks from E rising to Q rising, E falling and E rising again
	task automatic measure_eq(output int q_rise, output int e_fall, output int period);
		int n;
		q_rise = -1;
		e_fall = -1;
		period = -1;
		wait_e_level(1'b0);
		wait_e_level(1'b1);
		for (n = 1; n <= 40; n++) begin
			@(posedge clk_49m);
			#1;
			if (q_rise < 0 && cpu_q_o) q_rise = n;
			if (e_fall < 0 && !cpu_e_o) e_fall = n;
			if (e_fall >= 0 && cpu_e_o) begin
				period = n;
				break;
			end
		end
		if (period < 0) $display("Timeout: no full E period within 40 clocks at %0t", $time);
	endtask

	// ====================================================================
	// Test sequence
	// ====================================================================
	initial begin
		int                i;
		int                low_clocks;
		int                q_rise, e_fall, period;
		int                changes;
		bit                back_high;
		bit                cs;
		logic [data_w-1:0] din;
		logic              e_held, q_held;

		errors = 0;
		checks = 0;
		void'($urandom(32'h217c));
		for (i = 0; i < 3; i++) ram_val[i] = 8'($urandom());
		dip_sw_i = 16'($urandom());
		in0_i    = 8'($urandom());
		in1_i    = 8'($urandom());
		in2_i    = 8'($urandom());

		reset        = 1'b0;
		pause_i      = 1'b0;
		cpu_addr_i   = 16'h0000;
		cpu_dout_i   = 8'h00;
		cpu_rnw_i    = 1'b1;
		vblank_irq_i = 1'b0;
		repeat (16) @(posedge clk_49m);
		#1 reset = 1'b1;

		// Work RAM and unmapped space
		add_table_row(1, 16'h8800, ram_val[0], 8'h00);
		add_table_row(1, 16'h8C55, ram_val[1], 8'h00);
		add_table_row(1, 16'h8FFF, ram_val[2], 8'h00);
		add_table_row(0, 16'h8800, 8'h00, ram_val[0]);
		add_table_row(0, 16'h8C55, 8'h00, ram_val[1]);
		add_table_row(0, 16'h8FFF, 8'h00, ram_val[2]);
		add_table_row(0, 16'h0100, 8'h00, 8'hFF);
		add_table_row(0, 16'h8300, 8'h00, 8'hFF);
		// Main ROM, index is region minus 0xA
		add_table_row(0, 16'hA000, 8'h00, rom_byte({5'd0, 12'h000}));
		add_table_row(0, 16'hF123, 8'h00, rom_byte({5'd5, 12'h123}));
		// Banked window, index is 6 plus bank
		add_table_row(1, 16'h8300, 8'h00, 8'h00);
		add_table_row(0, 16'h9ABC, 8'h00, rom_byte({5'd6, 12'hABC}));
		add_table_row(1, 16'h8300, 8'h04, 8'h00);
		add_table_row(0, 16'h9ABC, 8'h00, rom_byte({5'd10, 12'hABC}));
		add_table_row(1, 16'h8300, 8'h08, 8'h00);
		add_table_row(0, 16'h9ABC, 8'h00, rom_byte({5'd14, 12'hABC}));
		add_table_row(1, 16'h8300, 8'h0C, 8'h00);
		add_table_row(0, 16'h9ABC, 8'h00, 8'hFF);   // No image behind bank 12
		// Switches and controls read inverted
		add_table_row(0, 16'h81E0, 8'h00, ~dip_sw_i[7:0]);
		add_table_row(0, 16'h8160, 8'h00, ~dip_sw_i[15:8]);
		add_table_row(0, 16'h8180, 8'h00, ~in0_i);
		add_table_row(0, 16'h81A0, 8'h00, ~in1_i);
		add_table_row(0, 16'h81C0, 8'h00, ~in2_i);

		wait_e_level(1'b1); // Line up on an E fall
		wait_e_level(1'b0);
		for (i = 0; i < tbl_addr.size(); i++) begin
			run_bus_cycle(tbl_wr[i], tbl_addr[i], tbl_wdata[i], din, cs);
			if (!tbl_wr[i]) begin
				check_value($sformatf("cpu_din_o[0x%04h]", tbl_addr[i]), 32'(din),
					32'(tbl_exp[i]));
			end
		end

		// Full linear ROM address, A11..A8 never reach the model byte
		run_bus_cycle(0, 16'hF123, 8'h00, din, cs);
		check_value("rom_addr_o[0xF123]", 32'(rom_addr_o), 32'({5'd5, 12'h123}));
		run_bus_cycle(1, 16'h8300, 8'h03, din, cs); // Bank 3
		run_bus_cycle(0, 16'h9ABC, 8'h00, din, cs);
		check_value("rom_addr_o[0x9ABC]", 32'(rom_addr_o), 32'({5'd9, 12'hABC}));

		// ================================================================
		// VBlank NMI
		// ================================================================
		pulse_vblank(low_clocks, back_high);
		check_value("nmi_n_o low clocks, mask clear", low_clocks, 0);
		run_bus_cycle(1, 16'h8200, 8'h01, din, cs); // Set NMI mask
		run_bus_cycle(0, 16'h0100, 8'h00, din, cs); // Idle read
		pulse_vblank(low_clocks, back_high);
		check_value("nmi_n_o low clocks, mask set", low_clocks, 8);
		if (!back_high) begin
			errors++;
			$display("Timeout: nmi_n_o did not return high within 48 clocks at %0t", $time);
		end

		// Sound IRQ, flip and sound-command select
		run_bus_cycle(1, 16'h8202, 8'h01, din, cs);
		check_value("irq_trigger_o", 32'(irq_trigger_o), 1);
		check_value("cs_sounddata_o on latch write", 32'(cs), 0);
		run_bus_cycle(1, 16'h8202, 8'h00, din, cs);
		check_value("irq_trigger_o", 32'(irq_trigger_o), 0);
		run_bus_cycle(1, 16'h8201, 8'h01, din, cs);
		check_value("flip_o", 32'(flip_o), 1);
		run_bus_cycle(1, 16'h8700, 8'h5A, din, cs);
		check_value("cs_sounddata_o on 0x8700 write", 32'(cs), 1);
		run_bus_cycle(0, 16'h8700, 8'h00, din, cs);
		check_value("cs_sounddata_o on 0x8700 read", 32'(cs), 0);

		// ================================================================
		// E and Q phases
		// ================================================================
		measure_eq(q_rise, e_fall, period);
		check_value("cpu_q_o rise after E", q_rise, 8);
		check_value("cpu_e_o high clocks", e_fall, 16);
		check_value("cpu_e_o period", period, 32);

		pause_i = 1'b1;
		e_held  = cpu_e_o;
		q_held  = cpu_q_o;
		changes = 0;
		repeat (64) begin
			@(posedge clk_49m);
			#1;
			if (cpu_e_o !== e_held || cpu_q_o !== q_held) changes++;
		end
		check_value("E/Q changes while paused", changes, 0);
		pause_i = 1'b0;
		wait_e_level(~e_held); // E moves again once released

		$display("Closing: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: files.f
design/board_pkg.sv
design/clock_gen.sv
design/addr_decoder.sv
design/board_regs.sv
design/work_ram.sv
design/cpu_read_mux.sv
design/tutankham_board.sv
dv/tb_tutankham_board.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module tb_tutankham_board \
	-Mdir obj_dir -o sim_tutankham \
	&& ./obj_dir/sim_tutankham | tee sim.log \
	|| { echo "Build or simulation run failed"; exit 1; }
grep -q "^ALL TESTS PASSED$" sim.log \
	&& echo "Log shows a passing run" \
	|| { echo "Log shows a failing run"; exit 1; }
